// ==== common/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// first fetch address after rst
`define RV_RESET_PC 32'h0000_0000

// rv32e register file shape
`define RV_REG_COUNT 16
`define RV_REG_AW 4             // index width for RV_REG_COUNT entries

`endif

// ==== common/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // r view also carries the funct fields and register indices
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_insn_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_insn_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        logic [6:0] opcode;
    } rv_insn_s_t;

    // u and j share the upper 20 bits, j scrambles them
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_insn_uj_t;

    typedef union packed {
        rv_insn_r_t  r;
        rv_insn_i_t  i;
        rv_insn_s_t  s;
        rv_insn_uj_t uj;
    } rv_insn_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } rv_alu_op_e;

    // operand pair key, a/b
    typedef enum logic [1:0] {
        OPSEL_ZERO_IMM = 2'b00, // lui
        OPSEL_PC_IMM   = 2'b01, // auipc, jal
        OPSEL_RS1_RS2  = 2'b10,
        OPSEL_RS1_IMM  = 2'b11
    } rv_opsel_e;

    typedef struct packed {
        rv_alu_op_e alu_op;
        rv_opsel_e  opsel;
        logic       jump;           // next pc comes from the alu
        logic       link;           // rd gets pc + 4
        logic       mem_rd;
        logic       mem_wr;
        logic [1:0] mem_size;       // 0 byte, 1 half, 2 word
        logic       mem_unsigned;
        logic       rd_we;
        logic       ebreak;
    } rv_ctrl_t;

    // wishbone classic master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat_w;
    } rv_wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } rv_wb_rsp_t;

endpackage

`default_nettype wire

// ==== exu/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  rv_alu_op_e  op,
    output logic [31:0] res
);

    logic [4:0] shamt;

    assign shamt = b[4:0];      // rv32 shifts use only five bits

    always_comb begin
        case (op)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_SLL:    res = a << shamt;
            ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   res = {31'b0, a < b};
            ALU_XOR:    res = a ^ b;
            ALU_SRL:    res = a >> shamt;
            ALU_SRA:    res = $unsigned($signed(a) >>> shamt);   // sign fill
            ALU_OR:     res = a | b;
            ALU_AND:    res = a & b;
            ALU_PASS_B: res = b;        // lui
            default:    res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== exu/rv_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exu import rv_core_pkg::*; (
    input  rv_ctrl_t    ctrl,
    input  logic [31:0] rs1_d,
    input  logic [31:0] rs2_d,
    input  logic [31:0] imm,
    input  logic [31:0] pc,
    input  logic [31:0] mem_rdata,
    output logic [31:0] rd_d,
    output logic [31:0] dnpc,
    output logic [31:0] mem_adr,
    output logic [3:0]  mem_sel,
    output logic [31:0] mem_wdata
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    logic [1:0]  byte_off;
    logic [31:0] lane;          // load word with the addressed byte at bit 0
    logic [31:0] load_val;

    // operand pair picked by the decoded key
    always_comb begin
        case (ctrl.opsel)
            OPSEL_ZERO_IMM: begin
                op_a = '0;
                op_b = imm;
            end
            OPSEL_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            OPSEL_RS1_RS2: begin
                op_a = rs1_d;
                op_b = rs2_d;
            end
            default: begin
                op_a = rs1_d;
                op_b = imm;
            end
        endcase
    end

    rv_alu u_alu (
        .a   (op_a),
        .b   (op_b),
        .op  (ctrl.alu_op),
        .res (alu_res)
    );

    assign pc_plus4 = pc + 32'd4;
    assign dnpc     = ctrl.jump ? {alu_res[31:1], 1'b0} : pc_plus4;    // jalr clears bit 0

    // loads and stores use the alu sum as the byte address
    assign byte_off = alu_res[1:0];
    assign mem_adr  = {alu_res[31:2], 2'b00};

    always_comb begin
        case (ctrl.mem_size)
            2'd0: begin
                mem_sel   = 4'b0001 << byte_off;
                mem_wdata = {24'b0, rs2_d[7:0]} << {byte_off, 3'b000};
            end
            2'd1: begin
                mem_sel   = 4'b0011 << {byte_off[1], 1'b0};    // halves stay aligned
                mem_wdata = {16'b0, rs2_d[15:0]} << {byte_off[1], 4'b0000};
            end
            default: begin
                mem_sel   = 4'b1111;
                mem_wdata = rs2_d;
            end
        endcase
    end

    assign lane = mem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            2'd0:    load_val = ctrl.mem_unsigned ? {24'b0, lane[7:0]}
                                                  : {{24{lane[7]}}, lane[7:0]};
            2'd1:    load_val = ctrl.mem_unsigned ? {16'b0, lane[15:0]}
                                                  : {{16{lane[15]}}, lane[15:0]};
            default: load_val = mem_rdata;
        endcase
    end

    // writeback source
    assign rd_d = ctrl.mem_rd ? load_val :
                  ctrl.link   ? pc_plus4 : alu_res;

endmodule

`default_nettype wire

// ==== hw/rv_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_idu import rv_core_pkg::*; (
    input  rv_insn_u    ir,
    output rv_ctrl_t    ctrl,
    output logic [31:0] imm
);

    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic        op_legal;      // funct7 valid for an OP encoding
    logic        shift_legal;   // funct7 valid for a shift immediate
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // shared by OP and OP-IMM, alt picks sub/sra
    function automatic rv_alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        rv_alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign funct7 = ir.r.funct7;
    assign funct3 = ir.r.funct3;

    // only add/sub and srl/sra have an alternate form
    assign op_legal = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign shift_legal = (funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && funct3 == 3'b101);

    // each immediate read through its own view of the word
    assign imm_i = {{20{ir.i.imm[11]}}, ir.i.imm};
    assign imm_s = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
    assign imm_u = {ir.uj.imm, 12'b0};
    assign imm_j = {{12{ir.uj.imm[19]}}, ir.uj.imm[7:0], ir.uj.imm[8],
                    ir.uj.imm[18:9], 1'b0};

    always_comb begin
        ctrl = '0;              // unsupported words fall through as no-ops
        imm  = '0;
        case (ir.r.opcode)
            OPC_LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.opsel  = OPSEL_ZERO_IMM;
                ctrl.rd_we  = 1'b1;
                imm         = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.opsel = OPSEL_PC_IMM;  // pc + imm
                ctrl.rd_we = 1'b1;
                imm        = imm_u;
            end
            OPC_JAL: begin
                ctrl.opsel = OPSEL_PC_IMM;
                ctrl.jump  = 1'b1;
                ctrl.link  = 1'b1;
                ctrl.rd_we = 1'b1;
                imm        = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.opsel = OPSEL_RS1_IMM;
                    ctrl.jump  = 1'b1;
                    ctrl.link  = 1'b1;
                    ctrl.rd_we = 1'b1;
                    imm        = imm_i;
                end
            end
            OPC_OP_IMM: begin
                if ((funct3 != 3'b001 && funct3 != 3'b101) || shift_legal) begin
                    ctrl.alu_op = alu_from_f3(funct3, funct3 == 3'b101 && funct7[5]);
                    ctrl.opsel  = OPSEL_RS1_IMM;
                    ctrl.rd_we  = 1'b1;
                    imm         = imm_i;
                end
            end
            OPC_OP: begin
                if (op_legal) begin
                    ctrl.alu_op = alu_from_f3(funct3, funct7[5]);
                    ctrl.opsel  = OPSEL_RS1_RS2;
                    ctrl.rd_we  = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin   // lb lh lw lbu lhu
                    ctrl.opsel        = OPSEL_RS1_IMM;
                    ctrl.mem_rd       = 1'b1;
                    ctrl.mem_size     = funct3[1:0];
                    ctrl.mem_unsigned = funct3[2];
                    ctrl.rd_we        = 1'b1;
                    imm               = imm_i;
                end
            end
            OPC_STORE: begin
                if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                    ctrl.opsel    = OPSEL_RS1_IMM;
                    ctrl.mem_wr   = 1'b1;
                    ctrl.mem_size = funct3[1:0];
                    imm           = imm_s;
                end
            end
            OPC_SYSTEM: begin
                ctrl.ebreak = (ir == 32'h0010_0073);    // ebreak only, ecall ignored
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1_idx,
    input  logic [`RV_REG_AW-1:0] rs2_idx,
    input  logic [`RV_REG_AW-1:0] rd_idx,
    input  logic                  we,
    input  logic [31:0]           rd_d,
    output logic [31:0]           rs1_d,
    output logic [31:0]           rs2_d,
    output logic [31:0]           a0
);

    logic [31:0] regs [1:`RV_REG_COUNT-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_idx != '0) begin
            regs[rd_idx] <= rd_d;
        end
    end

    // async reads, x0 reads as zero
    assign rs1_d = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_d = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    assign a0    = regs[10];

endmodule

`default_nettype wire

// ==== hw/rv_core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core_ctrl import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  rv_ctrl_t    ctrl,
    input  logic [31:0] rd_d,
    input  logic [31:0] dnpc,
    input  logic [31:0] mem_adr,
    input  logic [3:0]  mem_sel,
    input  logic [31:0] mem_wdata,
    input  rv_wb_rsp_t  wb_rsp,
    output rv_wb_req_t  wb_req,
    output rv_insn_u    ir,
    output logic [31:0] pc,
    output logic        rf_we,
    output logic [31:0] rf_d,
    output logic        halted
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e      state;
    logic        req_cyc;       // drives cyc and stb together
    logic        req_we;
    logic [31:0] req_adr;
    logic [3:0]  req_sel;
    logic [31:0] req_dat;
    logic        is_mem;
    logic        issue_fetch;
    logic        issue_data;
    logic        fetch_done;
    logic        mem_done;

    assign is_mem      = ctrl.mem_rd | ctrl.mem_wr;
    assign issue_fetch = (state == S_FETCH) && !req_cyc;   // one idle cycle on entry
    assign issue_data  = (state == S_EXEC) && is_mem && !ctrl.ebreak;
    assign fetch_done  = (state == S_FETCH) && req_cyc && wb_rsp.ack;
    assign mem_done    = (state == S_MEM) && wb_rsp.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_FETCH;
            pc      <= `RV_RESET_PC;
            req_cyc <= 1'b0;
            req_we  <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (issue_fetch) begin
                        req_cyc <= 1'b1;
                        req_we  <= 1'b0;
                    end else if (fetch_done) begin
                        req_cyc <= 1'b0;        // drop right after ack
                        state   <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (ctrl.ebreak) begin
                        state <= S_HALT;
                    end else if (issue_data) begin
                        req_cyc <= 1'b1;
                        req_we  <= ctrl.mem_wr;
                        state   <= S_MEM;
                    end else begin
                        pc    <= dnpc;
                        state <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (mem_done) begin
                        req_cyc <= 1'b0;
                        req_we  <= 1'b0;
                        pc      <= dnpc;
                        state   <= S_FETCH;
                    end
                end
                default: ;              // halt is final until rst
            endcase
        end
    end

    // bus payload and instruction register, only valid behind cyc/state
    always_ff @(posedge clk) begin
        if (issue_fetch) begin
            req_adr <= pc;
            req_sel <= 4'b1111;
            req_dat <= '0;
        end else if (issue_data) begin
            req_adr <= mem_adr;
            req_sel <= mem_sel;
            req_dat <= mem_wdata;
        end
        if (fetch_done) begin
            ir <= wb_rsp.dat_r;
        end
    end

    assign wb_req = '{cyc: req_cyc, stb: req_cyc, we: req_we,
                      adr: req_adr, sel: req_sel, dat_w: req_dat};

    // alu and link results land at end of exec, loads on the mem ack
    assign rf_we = ((state == S_EXEC) && ctrl.rd_we && !ctrl.mem_rd) ||
                   (mem_done && ctrl.mem_rd && ctrl.rd_we);
    assign rf_d  = rd_d;
    assign halted = (state == S_HALT);

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core_top import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output rv_wb_req_t  wb_req,
    input  rv_wb_rsp_t  wb_rsp,
    output logic        halted,
    output logic [31:0] halt_code
);

    rv_insn_u    ir;
    rv_ctrl_t    ctrl;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] rs1_d;
    logic [31:0] rs2_d;
    logic [31:0] rd_d;
    logic [31:0] rf_d;
    logic [31:0] dnpc;
    logic [31:0] mem_adr;
    logic [3:0]  mem_sel;
    logic [31:0] mem_wdata;
    logic        rf_we;

    rv_core_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .wb_rsp    (wb_rsp),
        .wb_req    (wb_req),
        .ir        (ir),
        .pc        (pc),
        .rf_we     (rf_we),
        .rf_d      (rf_d),
        .halted    (halted)
    );

    rv_idu u_idu (
        .ir   (ir),
        .ctrl (ctrl),
        .imm  (imm)
    );

    // rv32e indices use the low bits of each field
    rv_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (ir.r.rs1[`RV_REG_AW-1:0]),
        .rs2_idx (ir.r.rs2[`RV_REG_AW-1:0]),
        .rd_idx  (ir.r.rd[`RV_REG_AW-1:0]),
        .we      (rf_we),
        .rd_d    (rf_d),
        .rs1_d   (rs1_d),
        .rs2_d   (rs2_d),
        .a0      (halt_code)    // frozen once halted
    );

    rv_exu u_exu (
        .ctrl      (ctrl),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .mem_rdata (wb_rsp.dat_r),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// isa reference state, separate from the bus memory
logic [31:0] m_x [0:15];
logic [31:0] m_mem [0:1023];
logic [31:0] m_pc;
logic        m_halted;
rv_wb_req_t  exp_q [$];         // predicted bus cycles, oldest first

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic expect_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat);
    rv_wb_req_t c;
    c       = '0;
    c.cyc   = 1'b1;
    c.stb   = 1'b1;
    c.we    = we;
    c.adr   = adr;
    c.sel   = sel;
    c.dat_w = dat;
    exp_q.push_back(c);
endtask

// one instruction, pushing its fetch and any data cycle
task automatic rv_model_step();
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] imm_i;
    logic [31:0] ea;
    logic [31:0] lane;
    logic [31:0] res;
    logic [31:0] wdat;
    logic [31:0] next_pc;
    logic [3:0]  sel;
    logic        wr;
    insn = m_mem[m_pc[11:2]];
    expect_cycle(1'b0, m_pc, 4'hf, 32'h0);
    a     = m_x[insn[18:15]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    ea    = a + ((insn[6:0] == 7'h23) ? {{20{insn[31]}}, insn[31:25], insn[11:7]} : imm_i);
    sel   = (insn[13:12] == 2'd0) ? 4'b0001 << ea[1:0] :
            (insn[13:12] == 2'd1) ? 4'b0011 << ea[1:0] : 4'b1111;
    lane    = m_mem[ea[11:2]] >> (8 * ea[1:0]);    // addressed byte at bit 0
    next_pc = m_pc + 32'd4;
    wr      = 1'b1;
    res     = '0;
    case (insn[6:0])
        7'h37: res = {insn[31:12], 12'h0};
        7'h17: res = m_pc + {insn[31:12], 12'h0};
        7'h6f: begin
            res     = m_pc + 32'd4;
            next_pc = m_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'h67: begin
            res     = m_pc + 32'd4;
            next_pc = (a + imm_i) & ~32'h1;
        end
        7'h13: res = model_alu(insn[14:12], insn[30] && insn[14:12] == 3'd5, a, imm_i);
        7'h33: res = model_alu(insn[14:12], insn[30], a, m_x[insn[23:20]]);
        7'h03: begin
            expect_cycle(1'b0, {ea[31:2], 2'b00}, sel, 32'h0);
            case (insn[14:12])
                3'd0:    res = {{24{lane[7]}}, lane[7:0]};
                3'd1:    res = {{16{lane[15]}}, lane[15:0]};
                3'd4:    res = {24'h0, lane[7:0]};
                3'd5:    res = {16'h0, lane[15:0]};
                default: res = lane;
            endcase
        end
        7'h23: begin
            // unused lanes carry zero
            wdat = (m_x[insn[23:20]] << (8 * ea[1:0])) &
                   {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
            expect_cycle(1'b1, {ea[31:2], 2'b00}, sel, wdat);
            for (int k = 0; k < 4; k++) begin
                if (sel[k]) begin
                    m_mem[ea[11:2]][8*k +: 8] = wdat[8*k +: 8];
                end
            end
            wr = 1'b0;
        end
        default: begin          // only ebreak left in generated code
            m_halted = 1'b1;
            wr       = 1'b0;
        end
    endcase
    if (wr && insn[10:7] != 4'd0) begin
        m_x[insn[10:7]] = res;
    end
    if (!m_halted) begin
        m_pc = next_pc;
    end
endtask

`endif

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module tb_rv_core import rv_core_pkg::*; ();

    logic        clk;
    logic        rst;
    rv_wb_req_t  wb_req;
    rv_wb_rsp_t  wb_rsp;
    logic        halted;
    logic [31:0] halt_code;

    logic [31:0] mem [0:1023];      // 4 KiB, code low, data 0x800 up
    logic [31:0] lfsr = 32'h7f5f_b0e0;
    logic [1:0]  wait_left;
    int          wp;                // next program word
    int          model_steps;
    logic        prog_ready;

    `include "tb_rv_model.svh"

    rv_core_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .halted    (halted),
        .halt_code (halt_code)
    );

    always #5 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
        stop_run();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [3:0] rs1,
                                          input logic [2:0] f3, input logic [3:0] rd,
                                          input logic [6:0] opc);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [3:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], 1'b0, rs2, 5'd14, f3, imm[4:0], 7'h23};   // base is always x14
    endfunction

    function automatic logic [3:0] pick_rd();
        logic [3:0] r;
        r = rand_bits(4);
        return (r == 4'd0 || r == 4'd14) ? 4'd10 : r;  // x14 keeps the data base
    endfunction

    function automatic logic [11:0] align_off(input logic [11:0] off, input logic [1:0] size);
        return (size == 2'd2) ? off & 12'hffc : (size == 2'd1) ? off & 12'hffe : off;
    endfunction

    // lui, auipc, op-imm or op with legal funct7
    function automatic logic [31:0] alu_word(input logic [3:0] rd);
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [19:0] up;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        kind = rand_bits(3);
        f3   = rand_bits(3);
        imm  = rand_bits(12);
        up   = rand_bits(20);
        rs1  = rand_bits(4);
        rs2  = rand_bits(4);
        case (kind)
            3'd0: return {up, 1'b0, rd, 7'h37};
            3'd1: return {up, 1'b0, rd, 7'h17};
            3'd2, 3'd3, 3'd4: begin
                if (f3 == 3'd1)
                    imm = {7'h00, imm[4:0]};
                else if (f3 == 3'd5)
                    imm = {1'b0, imm[10], 5'h00, imm[4:0]};     // srli or srai
                return enc_i(imm, rs1, f3, rd, 7'h13);
            end
            default: return {((f3 == 3'd0 || f3 == 3'd5) && imm[11]) ? 7'h20 : 7'h00,
                             1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'h33};
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[wp] = w;
        wp++;
    endtask

    task automatic gen_program();
        logic [3:0]  rd;
        logic [2:0]  kind;
        logic [1:0]  k;
        logic [1:0]  size;
        logic [11:0] off;
        logic [11:0] off2;
        logic        uns;
        logic        lsb;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = rand_bits(32);
        end
        wp = `RV_RESET_PC >> 2;
        emit({20'h00001, 1'b0, 4'd14, 7'h37});     // lui x14, 1 -> base 0x1000
        while (wp < 200) begin
            kind = rand_bits(3);
            rd   = pick_rd();
            k    = rand_bits(2);
            size = rand_bits(2);
            if (size == 2'd3)
                size = 2'd2;
            uns  = rand_bits(1) && size != 2'd2;
            off  = {1'b1, 11'(rand_bits(11))};     // -2048..-1 lands in 0x800..0xfff
            off2 = {1'b1, 11'(rand_bits(11))};
            case (kind)
                3'd3: begin     // load then store the result back
                    emit(enc_i(align_off(off, size), 4'd14, {uns, size}, rd, 7'h03));
                    emit(enc_s(off2 & 12'hffc, rd, 3'd2));
                end
                3'd4: emit(enc_s(align_off(off, size), rand_bits(4), {1'b0, size}));
                3'd5: begin     // jal over k skipped words
                    emit({1'b0, 6'h00, {1'b0, k} + 3'd1, 1'b0, 1'b0, 8'h00, 1'b0, rd, 7'h6f});
                    repeat (k) emit(alu_word(rd));
                end
                3'd6: begin     // auipc x13 then jalr past k words
                    lsb = rand_bits(1);     // odd target, core must clear bit 0
                    emit({20'h0, 1'b0, 4'd13, 7'h17});
                    emit(enc_i({8'h0, k, 1'b0, lsb} + 12'd8, 4'd13, 3'd0, rd, 7'h67));
                    repeat (k) emit(alu_word(rd));
                end
                default: begin
                    emit(alu_word(rd));
                    if (rand_bits(1))
                        emit(enc_s(off & 12'hffc, rd, 3'd2));
                end
            endcase
        end
        emit(32'h0010_0073);    // ebreak
    endtask

    task automatic run_model();
        for (int i = 0; i < 1024; i++) begin
            m_mem[i] = mem[i];
        end
        m_pc        = `RV_RESET_PC;
        m_halted    = 1'b0;
        model_steps = 0;
        for (int i = 0; i < 16; i++) begin
            m_x[i] = '0;
        end
        while (!m_halted && model_steps < 1000) begin
            rv_model_step();
            model_steps++;
        end
        assert (m_halted) else report_error("reference model never reached ebreak");
    endtask

    task automatic check_cycle();
        rv_wb_req_t exp;
        assert (exp_q.size() > 0) else report_error("bus request past the predicted program end");
        exp = exp_q.pop_front();
        assert (wb_req.we == exp.we) else report_mismatch("wb_req.we", exp.we, wb_req.we);
        assert (wb_req.adr == exp.adr) else report_mismatch("wb_req.adr", exp.adr, wb_req.adr);
        assert (wb_req.sel == exp.sel) else report_mismatch("wb_req.sel", exp.sel, wb_req.sel);
        if (exp.we)
            assert (wb_req.dat_w == exp.dat_w)
                else report_mismatch("wb_req.dat_w", exp.dat_w, wb_req.dat_w);
    endtask

    task automatic check_idle();
        assert (wb_req.cyc == 1'b0) else report_mismatch("wb_req.cyc", 32'd0, wb_req.cyc);
        assert (wb_req.stb == 1'b0) else report_mismatch("wb_req.stb", 32'd0, wb_req.stb);
        assert (halted == 1'b0) else report_mismatch("halted", 32'd0, halted);
    endtask

    // wishbone slave with 0..3 wait states
    always @(posedge clk) begin
        if (rst) begin
            wb_rsp <= '0;
        end else begin
            assert (!(halted && wb_req.cyc)) else report_error("bus request seen after halt");
            if (wb_rsp.ack) begin
                wb_rsp.ack <= 1'b0;         // one cycle only
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wait_left != 2'd0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    check_cycle();
                    wb_rsp.ack   <= 1'b1;
                    wb_rsp.dat_r <= mem[wb_req.adr[11:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req.we && wb_req.sel[b])
                            mem[wb_req.adr[11:2]][8*b +: 8] <= wb_req.dat_w[8*b +: 8];
                    end
                    wait_left <= rand_bits(2);
                end
            end
        end
    end

    initial begin
        wait (prog_ready);
        #((20 * model_steps + 200) * 10);   // 20 cycles per instruction plus margin
        report_error("timeout, core did not halt");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        wb_rsp     = '0;
        wait_left  = 2'd0;
        prog_ready = 1'b0;
        gen_program();
        run_model();
        prog_ready = 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_idle();           // state left by the first reset edge
        rst <= 1'b0;
        @(posedge clk);
        check_idle();
        wait (halted);
        repeat (10) @(posedge clk);
        assert (exp_q.size() == 0) else report_error("core halted with bus cycles still predicted");
        assert (halt_code == m_x[10]) else report_mismatch("halt_code", m_x[10], halt_code);
        for (int i = 0; i < 1024; i++) begin
            assert (mem[i] == m_mem[i])
                else report_mismatch($sformatf("mem[%0d]", i), m_mem[i], mem[i]);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
+incdir+testbench
common/rv_core_pkg.sv
exu/rv_alu.sv
exu/rv_exu.sv
hw/rv_idu.sv
hw/rv_regfile.sv
hw/rv_core_ctrl.sv
hw/rv_core_top.sv
testbench/tb_rv_core.sv
